// File: files.f
ahb_pkg.sv
dma_pkg.sv
dma_data_lane.sv
dma_addr_gen.sv
dma_beat_planner.sv
dma_master_fsm.sv
dma_ahb_master.sv
dma_ahb_master_properties.sv
tb_dma_ahb_master.sv

// File: Makefile
TOP = tb_dma_ahb_master

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_dma_ahb_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_ahb_master;

    localparam int NUM_ROWS = 9;
    localparam int MEM_SIZE = 4096;

    typedef struct packed {
        logic [31:0]          addr;
        int                   count;
        dma_pkg::elem_size_e  size;
        dma_pkg::burst_pref_e burst;
        logic                 write;
        logic                 inc;
        int                   err;
    } xfer_t;

    logic                        i_hclk;
    logic                        i_hnreset;
    logic [ahb_pkg::HADDR_W-1:0] o_haddr;
    logic                        o_hwrite;
    ahb_pkg::hsize_e             o_hsize;
    ahb_pkg::hburst_e            o_hburst;
    ahb_pkg::htrans_e            o_htrans;
    logic [ahb_pkg::HDATA_W-1:0] o_hwdata;
    logic                        hready;
    logic                        hresp;
    logic [ahb_pkg::HDATA_W-1:0] hrdata;
    logic                        i_req;
    logic                        o_ack;
    logic [ahb_pkg::HADDR_W-1:0] i_addr;
    logic [dma_pkg::COUNT_W-1:0] i_count;
    dma_pkg::elem_size_e         i_size;
    dma_pkg::burst_pref_e        i_burst;
    logic                        i_write;
    logic                        i_inc_en;
    logic [ahb_pkg::HDATA_W-1:0] i_wdata;
    logic [ahb_pkg::HDATA_W-1:0] o_rdata;
    logic                        o_data_strobe;
    logic                        o_idle;
    logic                        o_fail;

    // slave memory and the expected image
    logic [7:0]       mem [0:MEM_SIZE-1];
    logic [7:0]       exp_mem [0:MEM_SIZE-1];
    xfer_t            tbl [0:NUM_ROWS-1];
    xfer_t            cur;
    int               cur_blk;
    int               beat_no;
    int               burst_pos;
    int               cur_len;
    ahb_pkg::hburst_e cur_burst;
    int               wr_idx;
    int               rd_idx;
    int               mismatches;
    int               others;
    int               cycles;
    int               limit;
    logic [31:0]      rnd;

    // data phase in flight at the slave
    logic                        dp_valid;
    int                          dp_beat;
    logic [ahb_pkg::HADDR_W-1:0] dp_addr;
    logic                        dp_write;
    ahb_pkg::hsize_e             dp_size;

    dma_ahb_master dut (
        .i_hclk(i_hclk), .i_hnreset(i_hnreset),
        .o_haddr(o_haddr), .o_hwrite(o_hwrite), .o_hsize(o_hsize),
        .o_hburst(o_hburst), .o_htrans(o_htrans), .o_hwdata(o_hwdata),
        .i_hready(hready), .i_hresp(hresp), .i_hrdata(hrdata),
        .i_req(i_req), .o_ack(o_ack), .i_addr(i_addr), .i_count(i_count),
        .i_size(i_size), .i_burst(i_burst), .i_write(i_write),
        .i_inc_en(i_inc_en), .i_wdata(i_wdata), .o_rdata(o_rdata),
        .o_data_strobe(o_data_strobe), .o_idle(o_idle), .o_fail(o_fail)
    );

    always #5 i_hclk = ~i_hclk;

    // little endian word of the slave memory at the data phase address
    assign hrdata = {mem[{dp_addr[11:2], 2'd3}], mem[{dp_addr[11:2], 2'd2}],
                     mem[{dp_addr[11:2], 2'd1}], mem[{dp_addr[11:2], 2'd0}]};

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] fill_byte(input int unsigned a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ a[7:0];
    endfunction

    function automatic int step_of(input dma_pkg::elem_size_e s);
        return (s == dma_pkg::ES_BYTE) ? 1 : (s == dma_pkg::ES_HALF) ? 2 : 4;
    endfunction

    function automatic ahb_pkg::hsize_e hsize_of(input dma_pkg::elem_size_e s);
        return (s == dma_pkg::ES_BYTE) ? ahb_pkg::BYTE :
               (s == dma_pkg::ES_HALF) ? ahb_pkg::HALF : ahb_pkg::WORD;
    endfunction

    function automatic int burst_len(input dma_pkg::burst_pref_e b);
        return (b == dma_pkg::BP_INCR4) ? 4 : (b == dma_pkg::BP_INCR8) ? 8 :
               (b == dma_pkg::BP_INCR16) ? 16 : 1;
    endfunction

    function automatic ahb_pkg::hburst_e pref_hburst(input dma_pkg::burst_pref_e b);
        return (b == dma_pkg::BP_INCR4) ? ahb_pkg::INCR4 : (b == dma_pkg::BP_INCR8) ?
               ahb_pkg::INCR8 : (b == dma_pkg::BP_INCR16) ? ahb_pkg::INCR16 : ahb_pkg::SINGLE;
    endfunction

    function automatic logic [31:0] beat_addr(input int i);
        return cur.inc ? cur.addr + 32'(i * step_of(cur.size)) : cur.addr;
    endfunction

    function automatic logic [31:0] wdata_value(input int blk, input int beat);
        return 32'h3c00a55a ^ (32'(blk) << 20) ^ (32'(beat) * 32'h00010203);
    endfunction

    // zero-extended element from the expected image
    function automatic logic [31:0] lane_value(input logic [31:0] a);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < step_of(cur.size); k++) begin
            v[8*k +: 8] = exp_mem[12'(a + 32'(k))];
        end
        return v;
    endfunction

    function automatic logic [31:0] slave_value(input logic [31:0] a);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < step_of(cur.size); k++) begin
            v[8*k +: 8] = mem[12'(a + 32'(k))];
        end
        return v;
    endfunction

    task automatic check_htrans(input ahb_pkg::htrans_e got, input ahb_pkg::htrans_e exp,
                                input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
            mismatches++;
        end
    endtask

    task automatic check_hburst(input ahb_pkg::hburst_e got, input ahb_pkg::hburst_e exp,
                                input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
            mismatches++;
        end
    endtask

    task automatic check_hsize(input ahb_pkg::hsize_e got, input ahb_pkg::hsize_e exp,
                               input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %s expected %s", $time, msg, got.name(), exp.name());
            mismatches++;
        end
    endtask

    task automatic check_addr(input logic [ahb_pkg::HADDR_W-1:0] got,
                              input logic [ahb_pkg::HADDR_W-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_data(input logic [ahb_pkg::HDATA_W-1:0] got,
                              input logic [ahb_pkg::HDATA_W-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    // slave write takes each byte from its own lane of HWDATA
    task automatic store_write(input logic [31:0] a, input ahb_pkg::hsize_e s,
                               input logic [31:0] d);
        logic [31:0] b;
        int          k;
        for (k = 0; k < (1 << int'(s)); k++) begin
            b = a + 32'(k);
            mem[b[11:0]] = d[8*b[1:0] +: 8];
        end
    endtask

    // checks of one accepted address phase
    task automatic check_beat();
        int remaining;
        check_addr(o_haddr, beat_addr(beat_no), "address phase");
        check_flag(o_hwrite, cur.write, "hwrite");
        check_hsize(o_hsize, hsize_of(cur.size), "hsize");
        if (burst_pos == 0) begin
            check_htrans(o_htrans, ahb_pkg::NONSEQ, "first beat of burst");
            remaining = cur.count - beat_no;
            cur_len   = (remaining >= burst_len(cur.burst)) ? burst_len(cur.burst) : 1;
            cur_burst = (cur_len > 1) ? pref_hburst(cur.burst) : ahb_pkg::SINGLE;
        end else begin
            check_htrans(o_htrans, ahb_pkg::SEQ, "beat inside burst");
        end
        check_hburst(o_hburst, cur_burst, "burst type");
        burst_pos = (burst_pos + 1 == cur_len) ? 0 : burst_pos + 1;
        beat_no++;
    endtask

    always @(posedge i_hclk) begin : slave_model
        logic next_valid;
        int   next_beat;
        next_valid = dp_valid;
        next_beat  = dp_beat;
        if (dp_valid && hready) begin
            if (!hresp && dp_write) begin
                store_write(dp_addr, dp_size, o_hwdata);
            end
            next_valid = 1'b0;
        end
        if (hready && (o_htrans == ahb_pkg::NONSEQ || o_htrans == ahb_pkg::SEQ)) begin
            next_valid = 1'b1;
            next_beat  = beat_no;
            dp_addr   <= o_haddr;
            dp_write  <= o_hwrite;
            dp_size   <= o_hsize;
            check_beat();
        end
        dp_valid <= next_valid;
        dp_beat  <= next_beat;
        // two cycle error response or random wait states
        if (next_valid && next_beat == cur.err) begin
            hready <= hresp && !hready;
            hresp  <= 1'b1;
        end else if (next_valid) begin
            rnd = lcg_next(rnd);
            hready <= rnd[31:30] != 2'b00;
            hresp  <= 1'b0;
        end else begin
            hready <= 1'b1;
            hresp  <= 1'b0;
        end
        if (o_data_strobe) begin
            if (cur.write) begin
                wr_idx++;
                i_wdata <= wdata_value(cur_blk, wr_idx);
            end else begin
                check_data(o_rdata, lane_value(beat_addr(rd_idx)), "read data");
                rd_idx++;
            end
        end
        if (o_fail && o_htrans != ahb_pkg::IDLE) begin
            $display("transfer started after an error response at %0t", $time);
            others++;
        end
    end

    always @(posedge i_hclk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, a block never finished", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int          b;
        int          i;
        int          nbeats;
        logic [31:0] wv;
        tbl[0] = '{32'h100, 6, dma_pkg::ES_WORD, dma_pkg::BP_INCR4, 1'b1, 1'b1, -1};
        tbl[1] = '{32'h100, 6, dma_pkg::ES_WORD, dma_pkg::BP_INCR4, 1'b0, 1'b1, -1};
        tbl[2] = '{32'h203, 9, dma_pkg::ES_BYTE, dma_pkg::BP_INCR8, 1'b1, 1'b1, -1};
        tbl[3] = '{32'h202, 5, dma_pkg::ES_BYTE, dma_pkg::BP_SINGLE, 1'b0, 1'b1, -1};
        tbl[4] = '{32'h302, 20, dma_pkg::ES_HALF, dma_pkg::BP_INCR16, 1'b0, 1'b1, -1};
        tbl[5] = '{32'h402, 4, dma_pkg::ES_HALF, dma_pkg::BP_INCR4, 1'b1, 1'b0, -1};
        tbl[6] = '{32'h500, 10, dma_pkg::ES_WORD, dma_pkg::BP_INCR8, 1'b1, 1'b1, 5};
        tbl[7] = '{32'h600, 7, dma_pkg::ES_BYTE, dma_pkg::BP_INCR4, 1'b0, 1'b1, 2};
        tbl[8] = '{32'h700, 3, dma_pkg::ES_WORD, dma_pkg::BP_SINGLE, 1'b0, 1'b1, -1};
        for (i = 0; i < MEM_SIZE; i++) begin
            mem[i]     = fill_byte(i);
            exp_mem[i] = fill_byte(i);
        end
        limit = 200;
        for (b = 0; b < NUM_ROWS; b++) begin
            limit += tbl[b].count * 12 + 20;
        end
        i_hclk = 1'b0;
        i_hnreset = 1'b0;
        hready = 1'b1;
        hresp = 1'b0;
        i_req = 1'b0;
        i_addr = '0;
        i_count = '0;
        i_size = dma_pkg::ES_BYTE;
        i_burst = dma_pkg::BP_SINGLE;
        i_write = 1'b0;
        i_inc_en = 1'b0;
        i_wdata = '0;
        cur = tbl[0];
        cur.err = -1;
        rnd = 32'h07cfbfb9;
        dp_valid = 1'b0;
        dp_beat = 0;
        dp_addr = '0;
        dp_write = 1'b0;
        dp_size = ahb_pkg::BYTE;
        mismatches = 0;
        others = 0;
        cycles = 0;
        beat_no = 0;
        burst_pos = 0;
        cur_len = 1;
        cur_burst = ahb_pkg::SINGLE;
        wr_idx = 0;
        rd_idx = 0;
        cur_blk = 0;
        repeat (10) @(posedge i_hclk);
        i_hnreset <= 1'b1;
        @(posedge i_hclk);
        check_htrans(o_htrans, ahb_pkg::IDLE, "htrans after reset");
        check_flag(o_idle, 1'b1, "idle after reset");
        check_flag(o_ack, 1'b0, "ack after reset");
        check_flag(o_fail, 1'b0, "fail after reset");
        check_flag(o_data_strobe, 1'b0, "strobe after reset");

        for (b = 0; b < NUM_ROWS; b++) begin
            @(posedge i_hclk);
            cur = tbl[b];
            cur_blk = b;
            beat_no = 0;
            burst_pos = 0;
            wr_idx = 0;
            rd_idx = 0;
            nbeats = (cur.err < 0) ? cur.count : cur.err;
            if (cur.write) begin
                for (i = 0; i < nbeats; i++) begin
                    wv = wdata_value(b, i);
                    for (int k = 0; k < step_of(cur.size); k++) begin
                        exp_mem[12'(beat_addr(i) + 32'(k))] = wv[8*k +: 8];
                    end
                end
            end
            i_addr   <= cur.addr;
            i_count  <= dma_pkg::COUNT_W'(cur.count);
            i_size   <= cur.size;
            i_burst  <= cur.burst;
            i_write  <= cur.write;
            i_inc_en <= cur.inc;
            i_wdata  <= wdata_value(b, 0);
            i_req    <= 1'b1;
            while (!o_ack) @(posedge i_hclk);
            check_flag(o_fail, cur.err >= 0, "fail flag at ack");
            if (cur.write) begin
                check_data(32'(wr_idx), 32'(nbeats), "write strobes");
                for (i = 0; i < nbeats; i++) begin
                    check_data(slave_value(beat_addr(i)), lane_value(beat_addr(i)), "memory");
                end
            end else begin
                check_data(32'(rd_idx), 32'(nbeats), "read strobes");
            end
            i_req <= 1'b0;
            @(posedge i_hclk);
            while (o_ack) @(posedge i_hclk);
        end

        $display("errors: %0d mismatches, %0d other", mismatches, others);
        if (mismatches == 0 && others == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dma_ahb_master_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ahb_master_properties (
    input wire logic                        i_hclk,
    input wire logic                        i_hnreset,
    input wire logic                        i_req,
    input wire logic                        o_ack,
    input wire logic                        i_hready,
    input wire logic                        i_hresp,
    input wire logic [ahb_pkg::HADDR_W-1:0] o_haddr,
    input wire ahb_pkg::htrans_e            o_htrans,
    input wire logic                        o_idle,
    input wire logic                        o_fail
);

    ack_needs_req: assert property (@(posedge i_hclk) disable iff (!i_hnreset)
        $rose(o_ack) |-> $past(i_req))
        else $error("ack rose without a request");

    // an error response may cancel the pending transfer
    hold_on_wait: assert property (@(posedge i_hclk) disable iff (!i_hnreset)
        (!i_hready && !i_hresp && o_htrans != ahb_pkg::IDLE)
        |=> ($stable(o_haddr) && $stable(o_htrans)))
        else $error("address or htrans changed during a wait state");

    // bus rests while idle and a block opens with a nonseq
    idle_no_trans: assert property (@(posedge i_hclk) disable iff (!i_hnreset)
        o_idle |=> (($past(o_htrans) == ahb_pkg::IDLE)
                    && (o_idle || (o_htrans == ahb_pkg::NONSEQ))))
        else $error("transfer issued while idle or block not opened with nonseq");

    fail_then_ack: assert property (@(posedge i_hclk) disable iff (!i_hnreset)
        (o_fail && !o_ack && i_req && i_hready) |=> o_ack)
        else $error("fail not followed by ack");

endmodule

bind dma_ahb_master dma_ahb_master_properties u_props (
    .i_hclk    (i_hclk),
    .i_hnreset (i_hnreset),
    .i_req     (i_req),
    .o_ack     (o_ack),
    .i_hready  (i_hready),
    .i_hresp   (i_hresp),
    .o_haddr   (o_haddr),
    .o_htrans  (o_htrans),
    .o_idle    (o_idle),
    .o_fail    (o_fail)
);

`default_nettype wire

// File: dma_ahb_master.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ahb_master (
    input  logic                          i_hclk,
    input  logic                          i_hnreset,

    // AHB side
    output logic [ahb_pkg::HADDR_W-1:0]   o_haddr,
    output logic                          o_hwrite,
    output ahb_pkg::hsize_e               o_hsize,
    output ahb_pkg::hburst_e              o_hburst,
    output ahb_pkg::htrans_e              o_htrans,
    output logic [ahb_pkg::HDATA_W-1:0]   o_hwdata,
    input  logic                          i_hready,
    input  logic                          i_hresp,
    input  logic [ahb_pkg::HDATA_W-1:0]   i_hrdata,

    // controller side
    input  logic                          i_req,
    output logic                          o_ack,
    input  logic [ahb_pkg::HADDR_W-1:0]   i_addr,
    input  logic [dma_pkg::COUNT_W-1:0]   i_count,
    input  dma_pkg::elem_size_e           i_size,
    input  dma_pkg::burst_pref_e          i_burst,
    input  logic                          i_write,
    input  logic                          i_inc_en,
    input  logic [ahb_pkg::HDATA_W-1:0]   i_wdata,
    output logic [ahb_pkg::HDATA_W-1:0]   o_rdata,
    output logic                          o_data_strobe,
    output logic                          o_idle,
    output logic                          o_fail
);

    dma_pkg::master_state_e      state;
    logic                        start;
    logic                        addr_state;
    logic                        first_beat;
    logic                        end_beat;
    logic                        last_beat;
    logic                        beats_left_zero;
    logic [ahb_pkg::HADDR_W-1:0] data_addr;

    // a block may begin only between handshakes
    assign start      = i_req && !o_ack;
    assign addr_state = (state == dma_pkg::ST_ADDR) || (state == dma_pkg::ST_ADDATA);

    // control is only meaningful during an address phase
    assign o_hwrite = addr_state && i_write;
    assign o_hsize  = addr_state ? ahb_pkg::hsize_e'({1'b0, i_size}) : ahb_pkg::BYTE;

    dma_master_fsm u_fsm (
        .i_hclk            (i_hclk),
        .i_hnreset         (i_hnreset),
        .i_req             (i_req),
        .i_hready          (i_hready),
        .i_hresp           (i_hresp),
        .i_first_beat      (first_beat),
        .i_end_beat        (end_beat),
        .i_last_beat       (last_beat),
        .i_beats_left_zero (beats_left_zero),
        .o_state           (state),
        .o_ack             (o_ack),
        .o_htrans          (o_htrans),
        .o_data_strobe     (o_data_strobe),
        .o_idle            (o_idle),
        .o_fail            (o_fail)
    );

    dma_beat_planner u_planner (
        .i_hclk            (i_hclk),
        .i_hnreset         (i_hnreset),
        .i_state           (state),
        .i_start           (start),
        .i_hready          (i_hready),
        .i_count           (i_count),
        .i_burst           (i_burst),
        .o_hburst          (o_hburst),
        .o_first_beat      (first_beat),
        .o_end_beat        (end_beat),
        .o_last_beat       (last_beat),
        .o_beats_left_zero (beats_left_zero)
    );

    dma_addr_gen u_addr (
        .i_hclk      (i_hclk),
        .i_hnreset   (i_hnreset),
        .i_state     (state),
        .i_start     (start),
        .i_hready    (i_hready),
        .i_addr      (i_addr),
        .i_size      (i_size),
        .i_inc_en    (i_inc_en),
        .o_haddr     (o_haddr),
        .o_data_addr (data_addr)
    );

    dma_data_lane u_lane (
        .i_size      (i_size),
        .i_data_addr (data_addr),
        .i_hrdata    (i_hrdata),
        .i_wdata     (i_wdata),
        .o_rdata     (o_rdata),
        .o_hwdata    (o_hwdata)
    );

endmodule

`default_nettype wire

// File: dma_master_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dma_master_fsm (
    input  logic                   i_hclk,
    input  logic                   i_hnreset,
    input  logic                   i_req,
    input  logic                   i_hready,
    input  logic                   i_hresp,
    input  logic                   i_first_beat,
    input  logic                   i_end_beat,
    input  logic                   i_last_beat,
    input  logic                   i_beats_left_zero,
    output dma_pkg::master_state_e o_state,
    output logic                   o_ack,
    output ahb_pkg::htrans_e       o_htrans,
    output logic                   o_data_strobe,
    output logic                   o_idle,
    output logic                   o_fail
);

    dma_pkg::master_state_e nxt_state;
    logic                   addr_state;
    logic                   active;
    logic                   to_error;
    logic                   block_done;

    assign addr_state = (o_state == dma_pkg::ST_ADDR) || (o_state == dma_pkg::ST_ADDATA);
    assign active     = addr_state || (o_state == dma_pkg::ST_DATA);
    assign to_error   = active && i_hresp;

    // last data phase done, or second cycle of an error response
    assign block_done = ((o_state == dma_pkg::ST_DATA) && i_hready && !i_hresp
                         && i_beats_left_zero)
                        || ((o_state == dma_pkg::ST_ERROR) && i_hready);

    always_comb begin
        nxt_state = o_state;
        case (o_state)
            dma_pkg::ST_IDLE: begin
                if (i_req && !o_ack) begin
                    nxt_state = dma_pkg::ST_ADDR;
                end
            end
            dma_pkg::ST_ADDR: begin
                if (i_hresp) begin
                    nxt_state = dma_pkg::ST_ERROR;
                end else if (i_hready) begin
                    nxt_state = (i_end_beat || i_last_beat) ? dma_pkg::ST_DATA
                                                            : dma_pkg::ST_ADDATA;
                end
            end
            dma_pkg::ST_ADDATA: begin
                if (i_hresp) begin
                    nxt_state = dma_pkg::ST_ERROR;
                end else if (i_hready && (i_end_beat || i_last_beat)) begin
                    nxt_state = dma_pkg::ST_DATA;
                end
            end
            dma_pkg::ST_DATA: begin
                if (i_hresp) begin
                    nxt_state = dma_pkg::ST_ERROR;
                end else if (i_hready) begin
                    nxt_state = i_beats_left_zero ? dma_pkg::ST_IDLE : dma_pkg::ST_ADDR;
                end
            end
            dma_pkg::ST_ERROR: begin
                if (i_hready) begin
                    nxt_state = dma_pkg::ST_IDLE;
                end
            end
            default: nxt_state = dma_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_hclk, negedge i_hnreset) begin
        if (!i_hnreset) begin
            o_state <= dma_pkg::ST_IDLE;
            o_ack   <= 1'b0;
            o_fail  <= 1'b0;
        end else begin
            o_state <= nxt_state;
            // ack and fail are held until the controller drops req
            if (!i_req) begin
                o_ack  <= 1'b0;
                o_fail <= 1'b0;
            end else begin
                if (block_done) begin
                    o_ack <= 1'b1;
                end
                if (to_error) begin
                    o_fail <= 1'b1;
                end
            end
        end
    end

    assign o_htrans = !addr_state ? ahb_pkg::IDLE :
                      i_first_beat ? ahb_pkg::NONSEQ : ahb_pkg::SEQ;

    assign o_data_strobe = ((o_state == dma_pkg::ST_ADDATA) || (o_state == dma_pkg::ST_DATA))
                           && i_hready;
    assign o_idle = o_state == dma_pkg::ST_IDLE;

endmodule

`default_nettype wire

// File: dma_beat_planner.sv
`timescale 1ns/1ps
`default_nettype none

module dma_beat_planner (
    input  logic                          i_hclk,
    input  logic                          i_hnreset,
    input  dma_pkg::master_state_e        i_state,
    input  logic                          i_start,
    input  logic                          i_hready,
    input  logic [dma_pkg::COUNT_W-1:0]   i_count,
    input  dma_pkg::burst_pref_e          i_burst,
    output ahb_pkg::hburst_e              o_hburst,
    output logic                          o_first_beat,
    output logic                          o_end_beat,
    output logic                          o_last_beat,
    output logic                          o_beats_left_zero
);

    logic [dma_pkg::COUNT_W-1:0] beats_left;
    logic [dma_pkg::BEAT_W-1:0]  beat_cnt;
    logic [dma_pkg::BEAT_W-1:0]  pref_last;
    logic                        addr_state;
    logic                        addr_done;
    logic                        short_left;
    logic                        residual_q;
    logic                        residual;

    assign addr_state = (i_state == dma_pkg::ST_ADDR) || (i_state == dma_pkg::ST_ADDATA);
    assign addr_done  = addr_state && i_hready;

    // index of the last beat of the preferred burst
    always_comb begin
        case (i_burst)
            dma_pkg::BP_INCR4:  pref_last = 4'd3;
            dma_pkg::BP_INCR8:  pref_last = 4'd7;
            dma_pkg::BP_INCR16: pref_last = 4'd15;
            default:            pref_last = 4'd0;
        endcase
    end

    // fewer beats left than the preferred burst holds
    assign short_left = beats_left <= dma_pkg::COUNT_W'(pref_last);

    // decided at the first beat, then frozen for the rest of the burst
    assign residual = o_first_beat ? short_left : residual_q;

    always_ff @(posedge i_hclk, negedge i_hnreset) begin
        if (!i_hnreset) begin
            beats_left <= '0;
            beat_cnt   <= '0;
            residual_q <= 1'b0;
        end else if (i_state == dma_pkg::ST_IDLE) begin
            beat_cnt   <= '0;
            residual_q <= 1'b0;
            if (i_start) begin
                beats_left <= i_count;
            end
        end else if (addr_done) begin
            beats_left <= beats_left - 1'b1;
            residual_q <= residual;
            // burst ends on its last beat or on the last beat of the block
            if (o_end_beat || o_last_beat) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    assign o_first_beat      = beat_cnt == '0;
    assign o_end_beat        = residual ? 1'b1 : (beat_cnt == pref_last);
    assign o_last_beat       = beats_left == dma_pkg::COUNT_W'(1);
    assign o_beats_left_zero = beats_left == '0;

    always_comb begin
        if (!addr_state || residual) begin
            o_hburst = ahb_pkg::SINGLE;
        end else begin
            case (i_burst)
                dma_pkg::BP_INCR4:  o_hburst = ahb_pkg::INCR4;
                dma_pkg::BP_INCR8:  o_hburst = ahb_pkg::INCR8;
                dma_pkg::BP_INCR16: o_hburst = ahb_pkg::INCR16;
                default:            o_hburst = ahb_pkg::SINGLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dma_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dma_addr_gen (
    input  logic                          i_hclk,
    input  logic                          i_hnreset,
    input  dma_pkg::master_state_e        i_state,
    input  logic                          i_start,
    input  logic                          i_hready,
    input  logic [ahb_pkg::HADDR_W-1:0]   i_addr,
    input  dma_pkg::elem_size_e           i_size,
    input  logic                          i_inc_en,
    output logic [ahb_pkg::HADDR_W-1:0]   o_haddr,
    output logic [ahb_pkg::HADDR_W-1:0]   o_data_addr
);

    logic [ahb_pkg::HADDR_W-1:0] step;
    logic                        addr_done;

    assign addr_done = ((i_state == dma_pkg::ST_ADDR) || (i_state == dma_pkg::ST_ADDATA))
                       && i_hready;

    // one element further
    always_comb begin
        case (i_size)
            dma_pkg::ES_BYTE: step = 'd1;
            dma_pkg::ES_HALF: step = 'd2;
            default:          step = 'd4;
        endcase
    end

    always_ff @(posedge i_hclk, negedge i_hnreset) begin
        if (!i_hnreset) begin
            o_haddr <= '0;
        end else if ((i_state == dma_pkg::ST_IDLE) && i_start) begin
            o_haddr <= i_addr;
        end else if (addr_done && i_inc_en) begin
            o_haddr <= o_haddr + step;
        end
    end

    // data phase address for the read lane choice
    always_ff @(posedge i_hclk, negedge i_hnreset) begin
        if (!i_hnreset) begin
            o_data_addr <= '0;
        end else if (addr_done) begin
            o_data_addr <= o_haddr;
        end
    end

endmodule

`default_nettype wire

// File: dma_data_lane.sv
`timescale 1ns/1ps
`default_nettype none

module dma_data_lane (
    input  dma_pkg::elem_size_e           i_size,
    input  logic [ahb_pkg::HADDR_W-1:0]   i_data_addr,
    input  logic [ahb_pkg::HDATA_W-1:0]   i_hrdata,
    input  logic [ahb_pkg::HDATA_W-1:0]   i_wdata,
    output logic [ahb_pkg::HDATA_W-1:0]   o_rdata,
    output logic [ahb_pkg::HDATA_W-1:0]   o_hwdata
);

    localparam int unsigned HALF_W = 2 * ahb_pkg::BYTE_W;

    // read side, lane chosen by the low address bits
    always_comb begin
        case (i_size)
            dma_pkg::ES_BYTE: begin
                o_rdata = {{(ahb_pkg::HDATA_W - ahb_pkg::BYTE_W){1'b0}},
                           i_hrdata[i_data_addr[1:0] * ahb_pkg::BYTE_W +: ahb_pkg::BYTE_W]};
            end
            dma_pkg::ES_HALF: begin
                o_rdata = {{(ahb_pkg::HDATA_W - HALF_W){1'b0}},
                           i_hrdata[i_data_addr[1] * HALF_W +: HALF_W]};
            end
            default: o_rdata = i_hrdata;
        endcase
    end

    // write side, the slave takes whichever lane it needs
    always_comb begin
        case (i_size)
            dma_pkg::ES_BYTE: begin
                o_hwdata = {(ahb_pkg::HDATA_W / ahb_pkg::BYTE_W){i_wdata[ahb_pkg::BYTE_W-1:0]}};
            end
            dma_pkg::ES_HALF: begin
                o_hwdata = {(ahb_pkg::HDATA_W / HALF_W){i_wdata[HALF_W-1:0]}};
            end
            default: o_hwdata = i_wdata;
        endcase
    end

endmodule

`default_nettype wire

// File: dma_pkg.sv
`default_nettype none

package dma_pkg;

    // beat count of one block
    localparam int unsigned COUNT_W = 18;

    // position inside a burst, up to 16 beats
    localparam int unsigned BEAT_W = 4;

    // element size, same code as the low bits of hsize
    typedef enum logic [1:0] {
        ES_BYTE = 2'b00,
        ES_HALF = 2'b01,
        ES_WORD = 2'b10
    } elem_size_e;

    // burst the controller would like to use
    typedef enum logic [1:0] {
        BP_SINGLE = 2'b00,
        BP_INCR4  = 2'b01,
        BP_INCR8  = 2'b10,
        BP_INCR16 = 2'b11
    } burst_pref_e;

    // addata means address of one beat overlapping data of the one before
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_ADDR   = 3'd1,
        ST_ADDATA = 3'd2,
        ST_DATA   = 3'd3,
        ST_ERROR  = 3'd4
    } master_state_e;

endpackage

`default_nettype wire

// File: ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    // bus widths
    localparam int unsigned HADDR_W = 32;
    localparam int unsigned HDATA_W = 32;

    // one byte lane
    localparam int unsigned BYTE_W = 8;

    // htrans encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // hsize, only the sizes up to the bus width
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // full hburst encoding, the master drives only single and incrN
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_e;

endpackage

`default_nettype wire
